// File: Makefile
# Verilator build for the ring bus testbench

VERILATOR ?= verilator
TOP ?= ring_bus_tb
FILELIST ?= ring_bus.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: ring_bus.f
rtl/bus_timing_pkg.sv
rtl/bus_msg_pkg.sv
rtl/bus_ctrl.sv
rtl/bus_node.sv
rtl/ring_bus_top.sv
tb/ring_bus_tb.sv

// File: rtl/bus_ctrl.sv
`timescale 1ns/1ps

module bus_ctrl (
	input  logic CLK,
	input  logic RESET,
	input  logic din,
	output logic dout,
	output logic bus_clk
);

	bus_timing_pkg::ctrl_state_t state;
	bus_timing_pkg::ctrl_state_t next_state;
	bus_timing_pkg::start_cnt_t start_cnt;
	bus_timing_pkg::start_cnt_t next_start_cnt;
	bus_timing_pkg::half_cnt_t half_cnt;
	bus_timing_pkg::half_cnt_t next_half_cnt;
	bus_msg_pkg::bit_cnt_t bit_cnt;
	bus_msg_pkg::bit_cnt_t next_bit_cnt;
	logic next_bus_clk;
	logic hold;
	logic next_hold;
	logic level;
	logic next_level;
	logic half_done;
	logic last_bit;

	// Ring passes through unless holding own level
	assign dout = hold ? level : din;

	assign half_done = (half_cnt == bus_timing_pkg::half_cnt_t'(bus_timing_pkg::HALF_CYCLES - 1));
	assign last_bit = (bit_cnt == bus_msg_pkg::bit_cnt_t'(bus_msg_pkg::MSG_BITS - 1));

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= bus_timing_pkg::CTRL_IDLE;
			start_cnt <= bus_timing_pkg::start_cnt_t'(bus_timing_pkg::START_CYCLES - 1);
			half_cnt <= '0;
			bit_cnt <= '0;
			bus_clk <= 1'b1;
			hold <= 1'b1;
			level <= 1'b1;
		end
		else
		begin
			state <= next_state;
			start_cnt <= next_start_cnt;
			half_cnt <= next_half_cnt;
			bit_cnt <= next_bit_cnt;
			bus_clk <= next_bus_clk;
			hold <= next_hold;
			level <= next_level;
		end
	end

	always_comb
	begin
		next_state = state;
		next_start_cnt = start_cnt;
		next_half_cnt = half_cnt;
		next_bit_cnt = bit_cnt;
		next_bus_clk = bus_clk;
		next_hold = hold;
		next_level = level;

		case (state)
			bus_timing_pkg::CTRL_IDLE:
			begin
				next_start_cnt = bus_timing_pkg::start_cnt_t'(bus_timing_pkg::START_CYCLES - 1);
				next_half_cnt = '0;
				// Some node pulled the ring low
				if (!din)
					next_state = bus_timing_pkg::CTRL_WAIT_START;
			end

			bus_timing_pkg::CTRL_WAIT_START:
			begin
				if (start_cnt != '0)
					next_start_cnt = start_cnt - 1'b1;
				else
				begin
					next_state = bus_timing_pkg::CTRL_ARB;
					next_bus_clk = 1'b0;
				end
			end

			default:
			begin
				if (!half_done)
					next_half_cnt = half_cnt + 1'b1;
				else
				begin
					next_half_cnt = '0;
					if (!bus_clk)
					begin
						next_bus_clk = 1'b1;
						// Ack sampled here and held through the high half
						if (state == bus_timing_pkg::CTRL_ACK)
							next_level = din;
					end
					else
					begin
						// End of a bus period
						next_bus_clk = 1'b0;
						case (state)
							bus_timing_pkg::CTRL_ARB:
							begin
								next_state = bus_timing_pkg::CTRL_DATA;
								next_bit_cnt = '0;
								next_hold = 1'b0;
							end

							bus_timing_pkg::CTRL_DATA:
							begin
								if (last_bit)
								begin
									next_state = bus_timing_pkg::CTRL_EOM;
									next_hold = 1'b1;
									next_level = 1'b1;
								end
								else
									next_bit_cnt = bit_cnt + 1'b1;
							end

							bus_timing_pkg::CTRL_EOM:
							begin
								next_state = bus_timing_pkg::CTRL_ACK;
							end

							bus_timing_pkg::CTRL_ACK:
							begin
								next_state = bus_timing_pkg::CTRL_BACK_IDLE;
								next_level = 1'b1;
							end

							bus_timing_pkg::CTRL_BACK_IDLE:
							begin
								// Back to idle with the bus clock high
								next_state = bus_timing_pkg::CTRL_IDLE;
								next_bus_clk = 1'b1;
							end

							default:
							begin
								next_state = bus_timing_pkg::CTRL_IDLE;
								next_bus_clk = 1'b1;
							end
						endcase
					end
				end
			end
		endcase
	end

endmodule

// File: rtl/bus_msg_pkg.sv
package bus_msg_pkg;

	// Data bits per frame, sent MSB first
	localparam int MSG_BITS = 8;

	typedef logic [MSG_BITS-1:0] msg_byte_t;

	// Index of the data bit within a frame
	typedef logic [$clog2(MSG_BITS)-1:0] bit_cnt_t;

endpackage

// File: rtl/bus_node.sv
`timescale 1ns/1ps

module bus_node (
	input  logic                   CLK,
	input  logic                   RESET,
	input  logic                   bus_clk,
	input  logic                   din,
	output logic                   dout,
	input  bus_msg_pkg::msg_byte_t tx_data,
	input  logic                   tx_valid,
	output logic                   tx_ready,
	output bus_msg_pkg::msg_byte_t rx_data,
	output logic                   rx_valid,
	input  logic                   rx_ready
);

	bus_timing_pkg::ctrl_state_t phase;
	bus_msg_pkg::bit_cnt_t bit_cnt;
	bus_msg_pkg::msg_byte_t shift_q;
	logic clk_q;
	logic fall;
	logic rise;
	logic last_bit;
	logic shift_out;
	logic req;
	logic sender;
	logic drv;
	logic ack_drv;

	assign fall = clk_q & ~bus_clk;
	assign rise = ~clk_q & bus_clk;
	assign last_bit = (bit_cnt == bus_msg_pkg::bit_cnt_t'(bus_msg_pkg::MSG_BITS - 1));
	assign shift_out = (phase == bus_timing_pkg::CTRL_ARB) ||
		((phase == bus_timing_pkg::CTRL_DATA) && !last_bit);

	// Forward unless requesting, sending or acking
	assign dout = req ? 1'b0 : (sender ? drv : (ack_drv ? 1'b0 : din));

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			clk_q <= 1'b1;
			phase <= bus_timing_pkg::CTRL_IDLE;
			bit_cnt <= '0;
			req <= 1'b0;
			sender <= 1'b0;
			drv <= 1'b1;
			ack_drv <= 1'b0;
			tx_ready <= 1'b0;
			rx_valid <= 1'b0;
		end
		else
		begin
			clk_q <= bus_clk;
			tx_ready <= 1'b0;
			if (rx_valid && rx_ready)
				rx_valid <= 1'b0;

			case (phase)
				bus_timing_pkg::CTRL_IDLE:
				begin
					if (fall)
						phase <= bus_timing_pkg::CTRL_ARB;
					else
						req <= tx_valid;
				end

				bus_timing_pkg::CTRL_ARB:
				begin
					// High din means no requester upstream
					if (rise)
					begin
						sender <= req & din;
						req <= 1'b0;
					end
					else if (fall)
					begin
						phase <= bus_timing_pkg::CTRL_DATA;
						bit_cnt <= '0;
						drv <= shift_q[bus_msg_pkg::MSG_BITS-1];
					end
				end

				bus_timing_pkg::CTRL_DATA:
				begin
					if (fall)
					begin
						if (last_bit)
						begin
							phase <= bus_timing_pkg::CTRL_EOM;
							drv <= 1'b1;
						end
						else
						begin
							bit_cnt <= bit_cnt + 1'b1;
							drv <= shift_q[bus_msg_pkg::MSG_BITS-1];
						end
					end
				end

				bus_timing_pkg::CTRL_EOM:
				begin
					if (fall)
					begin
						phase <= bus_timing_pkg::CTRL_ACK;
						ack_drv <= !sender && !rx_valid;
					end
				end

				bus_timing_pkg::CTRL_ACK:
				begin
					if (rise)
					begin
						// Low ring here means the byte was taken
						if (sender && !din)
							tx_ready <= 1'b1;
						if (ack_drv)
							rx_valid <= 1'b1;
					end
					else if (fall)
					begin
						phase <= bus_timing_pkg::CTRL_BACK_IDLE;
						sender <= 1'b0;
						ack_drv <= 1'b0;
					end
				end

				default:
				begin
					if (rise)
						phase <= bus_timing_pkg::CTRL_IDLE;
				end
			endcase
		end
	end

	// Sender shifts out, receivers shift in
	always_ff @(posedge CLK)
	begin
		if ((phase == bus_timing_pkg::CTRL_ARB) && rise && req && din)
			shift_q <= tx_data;
		else if (sender && fall && shift_out)
			shift_q <= shift_q << 1;
		else if (!sender && rise && (phase == bus_timing_pkg::CTRL_DATA))
			shift_q <= {shift_q[bus_msg_pkg::MSG_BITS-2:0], din};

		if ((phase == bus_timing_pkg::CTRL_ACK) && rise && ack_drv)
			rx_data <= shift_q;
	end

endmodule

// File: rtl/bus_timing_pkg.sv
package bus_timing_pkg;

	// CLK cycles per bus clock half-period
	localparam int HALF_CYCLES = 2;

	// CLK cycles from request detection to the first bus clock fall
	localparam int START_CYCLES = 12;

	typedef logic [$clog2(START_CYCLES + 1)-1:0] start_cnt_t;
	typedef logic [$clog2(HALF_CYCLES + 1)-1:0] half_cnt_t;

	// Frame phases, also followed by every node
	typedef enum logic [2:0] {
		CTRL_IDLE,
		CTRL_WAIT_START,
		CTRL_ARB,
		CTRL_DATA,
		CTRL_EOM,
		CTRL_ACK,
		CTRL_BACK_IDLE
	} ctrl_state_t;

endpackage

// File: rtl/ring_bus_top.sv
`timescale 1ns/1ps

module ring_bus_top (
	input  logic                   CLK,
	input  logic                   RESET,
	input  bus_msg_pkg::msg_byte_t a_tx_data,
	input  logic                   a_tx_valid,
	output logic                   a_tx_ready,
	output bus_msg_pkg::msg_byte_t a_rx_data,
	output logic                   a_rx_valid,
	input  logic                   a_rx_ready,
	input  bus_msg_pkg::msg_byte_t b_tx_data,
	input  logic                   b_tx_valid,
	output logic                   b_tx_ready,
	output bus_msg_pkg::msg_byte_t b_rx_data,
	output logic                   b_rx_valid,
	input  logic                   b_rx_ready
);

	logic bus_clk;
	logic ctrl_to_a;
	logic a_to_b;
	logic b_to_ctrl;

	bus_ctrl ctrl (
		.CLK     (CLK),
		.RESET   (RESET),
		.din     (b_to_ctrl),
		.dout    (ctrl_to_a),
		.bus_clk (bus_clk)
	);

	// Node A sits first after the controller and wins ties
	bus_node node_a (
		.CLK      (CLK),
		.RESET    (RESET),
		.bus_clk  (bus_clk),
		.din      (ctrl_to_a),
		.dout     (a_to_b),
		.tx_data  (a_tx_data),
		.tx_valid (a_tx_valid),
		.tx_ready (a_tx_ready),
		.rx_data  (a_rx_data),
		.rx_valid (a_rx_valid),
		.rx_ready (a_rx_ready)
	);

	bus_node node_b (
		.CLK      (CLK),
		.RESET    (RESET),
		.bus_clk  (bus_clk),
		.din      (a_to_b),
		.dout     (b_to_ctrl),
		.tx_data  (b_tx_data),
		.tx_valid (b_tx_valid),
		.tx_ready (b_tx_ready),
		.rx_data  (b_rx_data),
		.rx_valid (b_rx_valid),
		.rx_ready (b_rx_ready)
	);

endmodule

// File: tb/ring_bus_tb.sv
`timescale 1ns/1ps

module ring_bus_tb;

	localparam int FRAME_CYCLES = bus_timing_pkg::START_CYCLES +
		12 * 2 * bus_timing_pkg::HALF_CYCLES;

	logic CLK;
	logic RESET;
	bus_msg_pkg::msg_byte_t tx_data [2];
	logic tx_valid [2];
	logic tx_ready [2];
	bus_msg_pkg::msg_byte_t rx_data [2];
	logic rx_valid [2];
	logic rx_ready [2];

	// Index 0 is node A and index 1 is node B
	bus_msg_pkg::msg_byte_t send_q [2][$];
	bus_msg_pkg::msg_byte_t model_q [2][$];
	bus_msg_pkg::msg_byte_t slot_q [2];
	logic dest_log [$];
	int log_mark;
	int accept_cnt [2];
	int taken_cnt [2];
	int gap [2];
	logic hold [2];
	logic valid_q [2];
	logic ready_q [2];
	logic rnd_mode;
	logic [31:0] lfsr_state;
	int cycle_cnt;
	int cycle_limit;
	int rec_kind [$];
	int rec_node [$];
	int rec_data [$];
	int rec_exp [$];

	ring_bus_top dut (
		.CLK        (CLK),
		.RESET      (RESET),
		.a_tx_data  (tx_data[0]),
		.a_tx_valid (tx_valid[0]),
		.a_tx_ready (tx_ready[0]),
		.a_rx_data  (rx_data[0]),
		.a_rx_valid (rx_valid[0]),
		.a_rx_ready (rx_ready[0]),
		.b_tx_data  (tx_data[1]),
		.b_tx_valid (tx_valid[1]),
		.b_tx_ready (tx_ready[1]),
		.b_rx_data  (rx_data[1]),
		.b_rx_valid (rx_valid[1]),
		.b_rx_ready (rx_ready[1])
	);

	initial
	begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic string sig_name(input logic n, input string suffix);
		return $sformatf("%s_%s", n ? "b" : "a", suffix);
	endfunction

	task automatic check_byte(input string name, input bus_msg_pkg::msg_byte_t got,
		input bus_msg_pkg::msg_byte_t expected);
		if (got !== expected)
			stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, expected));
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected)
			stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, expected));
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic int rand_bits(input int count);
		int value;
		int i;
		value = 0;
		for (i = 0; i < count; i++)
		begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic logic traffic_done();
		return send_q[0].size() == 0 && send_q[1].size() == 0 && !tx_valid[0] &&
			!tx_valid[1] && model_q[0].size() == 0 && model_q[1].size() == 0;
	endfunction

	task automatic drive_node(input logic n);
		if (tx_valid[n])
		begin
			if (accept_cnt[n] != taken_cnt[n])
			begin
				tx_valid[n] <= 1'b0;
				taken_cnt[n]++;
				gap[n] = rnd_mode ? rand_bits(4) : 0;
			end
		end
		else if (gap[n] > 0)
			gap[n]--;
		else if (send_q[n].size() > 0)
		begin
			tx_data[n] <= send_q[n].pop_front();
			tx_valid[n] <= 1'b1;
		end
		rx_ready[n] <= !hold[n] && (!rnd_mode || rand_bits(2) != 0);
	endtask

	// tx_ready pulses exactly when the other node takes the byte
	task automatic watch_node(input logic n);
		logic rise_here;
		logic rise_other;
		bus_msg_pkg::msg_byte_t expected;
		rise_here = rx_valid[n] && !valid_q[n];
		rise_other = rx_valid[!n] && !valid_q[!n];
		check_flag(sig_name(n, "tx_ready"), tx_ready[n], rise_other);
		if (tx_ready[n])
		begin
			check_flag(sig_name(n, "tx_valid"), tx_valid[n], 1'b1);
			accept_cnt[n]++;
		end
		if (valid_q[n] && !rx_valid[n])
			check_flag(sig_name(n, "rx_ready"), ready_q[n], 1'b1);
		if (rise_here)
		begin
			if (model_q[n].size() == 0)
				stop_with_failure($sformatf("node %s received a byte that was never sent",
					n ? "b" : "a"));
			else
			begin
				expected = model_q[n].pop_front();
				check_byte(sig_name(n, "rx_data"), rx_data[n], expected);
				slot_q[n] = expected;
				dest_log.push_back(n);
			end
		end
		else if (rx_valid[n])
			// A full slot keeps its byte until it is drained
			check_byte(sig_name(n, "rx_data"), rx_data[n], slot_q[n]);
	endtask

	task automatic load_tests(output int wait_sum);
		int fd;
		int kind;
		int node;
		int data;
		int expected;
		string line;
		wait_sum = 0;
		fd = $fopen("tb/ring_bus_tests.txt", "r");
		if (fd == 0)
			stop_with_failure("could not open the test file tb/ring_bus_tests.txt");
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line[0] != "#" &&
					$sscanf(line, "%h %h %h %h", kind, node, data, expected) == 4)
				begin
					rec_kind.push_back(kind);
					rec_node.push_back(node);
					rec_data.push_back(data);
					rec_exp.push_back(expected);
					if (kind == 0 || kind == 4)
						wait_sum += data;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_record(input int kind, input logic nd, input int data, input int expected);
		case (kind)
			0:
			begin
				repeat (data)
				begin
					@(negedge CLK);
					check_flag("a_rx_valid", rx_valid[0], 1'b0);
					check_flag("b_rx_valid", rx_valid[1], 1'b0);
					check_flag("a_tx_ready", tx_ready[0], 1'b0);
					check_flag("b_tx_ready", tx_ready[1], 1'b0);
				end
			end
			1:
			begin
				send_q[nd].push_back(data[7:0]);
				model_q[!nd].push_back(expected[7:0]);
			end
			2:
			begin
				while (!traffic_done())
					@(negedge CLK);
				// Which node got the first byte since the last drain
				if (expected != 'hff && dest_log[log_mark] !== expected[0])
					stop_with_failure("bytes were delivered in the wrong order between nodes");
				log_mark = dest_log.size();
			end
			3:
				hold[nd] = data[0];
			4:
			begin
				repeat (data) @(negedge CLK);
				check_flag(sig_name(nd, "rx_valid"), rx_valid[nd], expected[0]);
			end
			5:
				rnd_mode = data[0];
			default:
				stop_with_failure($sformatf("unknown record kind %0d in the test file", kind));
		endcase
	endtask

	initial
	begin
		lfsr_state = 32'h9ae8c50f;
		taken_cnt = '{0, 0};
		gap = '{0, 0};
		tx_data = '{8'h00, 8'h00};
		tx_valid = '{1'b0, 1'b0};
		rx_ready = '{1'b0, 1'b0};
		forever
		begin
			@(posedge CLK);
			drive_node(1'b0);
			drive_node(1'b1);
		end
	end

	initial
	begin
		accept_cnt = '{0, 0};
		valid_q = '{1'b0, 1'b0};
		ready_q = '{1'b0, 1'b0};
		slot_q = '{8'h00, 8'h00};
		forever
		begin
			@(negedge CLK);
			if (RESET)
			begin
				watch_node(1'b0);
				watch_node(1'b1);
			end
			valid_q = rx_valid;
			ready_q = rx_ready;
		end
	end

	initial
	begin
		cycle_cnt = 0;
		wait (cycle_limit > 0);
		while (cycle_cnt < cycle_limit)
		begin
			@(posedge CLK);
			cycle_cnt++;
		end
		stop_with_failure($sformatf("timeout after %0d cycles without finishing the tests",
			cycle_limit));
	end

	initial
	begin
		int wait_sum;
		int i;
		RESET = 1'b0;
		hold = '{1'b0, 1'b0};
		rnd_mode = 1'b0;
		log_mark = 0;
		cycle_limit = 0;
		load_tests(wait_sum);
		cycle_limit = rec_kind.size() * 4 * FRAME_CYCLES + wait_sum + 1000;
		repeat (8) @(posedge CLK);
		RESET <= 1'b1;
		for (i = 0; i < rec_kind.size(); i++)
			run_record(rec_kind[i], rec_node[i] != 0, rec_data[i], rec_exp[i]);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: tb/ring_bus_tests.txt
# kind node byte expected, all hex, node 0 is A and node 1 is B
# kinds 0 idle cycles, 1 send, 2 drain (expected first receiver or ff), 3 hold rx_ready,
# 4 wait cycles then expected rx_valid, 5 random gaps and stalls
0 0 40 00
1 0 a5 a5
2 0 00 01
1 1 3c 3c
2 0 00 00
1 0 81 81
1 1 7e 7e
2 0 00 01
3 1 01 00
1 0 11 11
1 0 22 22
4 1 190 01
3 1 00 00
2 0 00 01
5 0 01 00
1 0 5a 5a
1 1 c3 c3
1 0 0f 0f
1 1 f0 f0
1 0 96 96
1 1 69 69
1 0 e7 e7
2 0 00 ff
